// File: list.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/hazard_unit.sv
hw/cpu_top.sv
testbench/cpu_properties.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module cpu_tb -f list.f -o cpu_sim \
	&& ./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log && echo "run.sh: simulation ok" \
	|| { echo "run.sh: simulation did not pass"; exit 1; }

// File: testbench/cpu_tb.sv
module cpu_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic                clk = 1'b0;
	logic                rst = 1'b1;
	logic                instr_valid = 1'b0;
	isa_pkg::instr_u     instr = '0;
	pipe_pkg::wb_event_t result;
	logic                err;
	logic                exp_valid = 1'b0;
	logic                exp_write = 1'b0;
	logic [2:0]          exp_reg = '0;
	logic [15:0]         exp_val = '0;
	logic                exp_err = 1'b0;
	logic                done = 1'b0;
	logic                table_ready = 1'b0;
	int                  fail_count;
	int                  pending;

	// Stimulus table, one row per instruction
	logic [15:0] tab_instr[64];
	int          tab_gap[64];
	logic        tab_exact[64];
	logic        tab_write[64];
	logic [2:0]  tab_reg[64];
	logic [15:0] tab_val[64];
	logic        tab_err[64];
	int          row_count = 0;

	always #5 clk = ~clk;

	cpu_top dut0 (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
		.result(result), .err(err)
	);

	cpu_checker chk0 (
		.clk(clk), .rst(rst), .exp_valid(exp_valid), .exp_write(exp_write),
		.exp_reg(exp_reg), .exp_val(exp_val), .exp_err(exp_err), .result(result),
		.err(err), .done(done), .fail_count(fail_count), .pending(pending)
	);

	bind cpu_top cpu_properties props0 (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .result(result), .err(err)
	);

	function automatic logic [15:0] enc_r(logic [4:0] op, logic [2:0] rs, logic [2:0] rt,
		logic [2:0] rd, logic [1:0] fn);
		return {op, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] enc_i1(logic [4:0] op, logic [2:0] rs, logic [2:0] rd,
		logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] enc_i2(logic [4:0] op, logic [2:0] rs, logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	task automatic add_row(logic [15:0] word, int gap, logic exact, logic wr, logic [2:0] rg,
		logic [15:0] val, logic e);
		tab_instr[row_count] = word;
		tab_gap[row_count]   = gap;
		tab_exact[row_count] = exact;
		tab_write[row_count] = wr;
		tab_reg[row_count]   = rg;
		tab_val[row_count]   = val;
		tab_err[row_count]   = e;
		row_count = row_count + 1;
	endtask

	task automatic build_table();
		// Immediate forms and byte loads
		add_row(enc_i2(isa_pkg::OP_LBI, 1, 8'h34), 1, 0, 1, 1, 16'h0034, 0);
		add_row(enc_i2(isa_pkg::OP_SLBI, 1, 8'h12), 1, 0, 1, 1, 16'h3412, 0);
		add_row(enc_i2(isa_pkg::OP_LBI, 2, 8'hf0), 1, 0, 1, 2, 16'hfff0, 0);
		add_row(enc_i1(isa_pkg::OP_ADDI, 1, 3, 5'h05), 1, 0, 1, 3, 16'h3417, 0);
		add_row(enc_i1(isa_pkg::OP_SUBI, 2, 4, 5'h1f), 1, 0, 1, 4, 16'h000f, 0);
		add_row(enc_i1(isa_pkg::OP_XORI, 1, 5, 5'h1f), 1, 0, 1, 5, 16'h340d, 0);
		add_row(enc_i1(isa_pkg::OP_ANDNI, 2, 6, 5'h10), 1, 0, 1, 6, 16'hffe0, 0);
		add_row(enc_i1(isa_pkg::OP_ROLI, 1, 7, 5'h04), 1, 0, 1, 7, 16'h4123, 0);
		add_row(enc_i1(isa_pkg::OP_SLLI, 2, 7, 5'h03), 1, 0, 1, 7, 16'hff80, 0);
		add_row(enc_i1(isa_pkg::OP_RORI, 1, 3, 5'h08), 1, 0, 1, 3, 16'h1234, 0);
		add_row(enc_i1(isa_pkg::OP_SRLI, 2, 4, 5'h0c), 3, 0, 1, 4, 16'h000f, 0);
		// Register forms
		add_row(enc_r(isa_pkg::OP_ALU_ARITH, 1, 3, 5, 0), 1, 0, 1, 5, 16'h4646, 0);
		add_row(enc_r(isa_pkg::OP_ALU_ARITH, 4, 3, 6, 1), 1, 0, 1, 6, 16'h1225, 0);
		add_row(enc_r(isa_pkg::OP_ALU_ARITH, 1, 3, 7, 2), 1, 0, 1, 7, 16'h2626, 0);
		add_row(enc_r(isa_pkg::OP_ALU_ARITH, 2, 1, 5, 3), 1, 0, 1, 5, 16'hcbe0, 0);
		add_row(enc_r(isa_pkg::OP_ALU_SHIFT, 1, 4, 6, 0), 1, 0, 1, 6, 16'h1a09, 0);
		add_row(enc_r(isa_pkg::OP_ALU_SHIFT, 3, 1, 7, 1), 1, 0, 1, 7, 16'h48d0, 0);
		add_row(enc_r(isa_pkg::OP_ALU_SHIFT, 2, 4, 5, 2), 1, 0, 1, 5, 16'hffe1, 0);
		add_row(enc_r(isa_pkg::OP_ALU_SHIFT, 2, 3, 6, 3), 3, 0, 1, 6, 16'h0fff, 0);
		// Back-to-back chain through both forwarding paths and the bypass
		add_row(enc_i2(isa_pkg::OP_LBI, 1, 8'h01), 0, 1, 1, 1, 16'h0001, 0);
		add_row(enc_i1(isa_pkg::OP_ADDI, 1, 2, 5'h01), 0, 1, 1, 2, 16'h0002, 0);
		add_row(enc_r(isa_pkg::OP_ALU_ARITH, 1, 2, 3, 0), 0, 1, 1, 3, 16'h0003, 0);
		add_row(enc_r(isa_pkg::OP_ALU_ARITH, 3, 1, 4, 0), 0, 1, 1, 4, 16'h0004, 0);
		add_row(enc_r(isa_pkg::OP_ALU_ARITH, 4, 2, 5, 0), 2, 0, 1, 5, 16'h0006, 0);
		// Store then load back
		add_row(enc_i2(isa_pkg::OP_LBI, 6, 8'h5a), 1, 0, 1, 6, 16'h005a, 0);
		add_row(enc_i1(isa_pkg::OP_ST, 0, 6, 5'h03), 1, 0, 0, 0, 16'h0000, 0);
		add_row(enc_i1(isa_pkg::OP_LD, 0, 7, 5'h03), 1, 0, 1, 7, 16'h005a, 0);
		add_row(enc_i1(isa_pkg::OP_ADDI, 7, 1, 5'h01), 2, 0, 1, 1, 16'h005b, 0);
		// Load-use one cycle apart, then an unknown opcode
		add_row(enc_i1(isa_pkg::OP_LD, 0, 2, 5'h03), 0, 1, 1, 2, 16'h005a, 0);
		add_row(enc_i1(isa_pkg::OP_ST, 0, 2, 5'h09), 2, 0, 0, 0, 16'h0000, 1);
		add_row(enc_i1(5'b11111, 1, 1, 5'h00), 2, 0, 0, 0, 16'h0000, 1);
		add_row(enc_i1(isa_pkg::OP_NOP, 0, 0, 5'h00), 2, 0, 0, 0, 16'h0000, 0);
		add_row(enc_i1(isa_pkg::OP_ADDI, 2, 3, 5'h00), 2, 0, 1, 3, 16'h005a, 0);
	endtask

	// Watchdog sized from the table
	initial begin
		int max_gap;
		int limit;
		wait (table_ready);
		max_gap = 0;
		for (int i = 0; i < row_count; i++)
			if (tab_gap[i] > max_gap)
				max_gap = tab_gap[i];
		limit = row_count * (max_gap + 2 + 6) + 50;
		repeat (limit) @(posedge clk);
		$display("Run timed out after %0d cycles with %0d results outstanding", limit, pending);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		int extra;
		void'($urandom(32'hfbb2641b));
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < row_count; i++) begin
			instr_valid <= 1'b1;
			instr       <= tab_instr[i];
			exp_valid   <= 1'b1;
			exp_write   <= tab_write[i];
			exp_reg     <= tab_reg[i];
			exp_val     <= tab_val[i];
			exp_err     <= tab_err[i];
			@(posedge clk);
			instr_valid <= 1'b0;
			exp_valid   <= 1'b0;
			extra = tab_exact[i] ? 0 : $urandom % 3;
			repeat (tab_gap[i] + extra) @(posedge clk);
		end
		repeat (2) @(posedge clk);
		wait (pending == 0);
		// Room for any stray strobe or err
		repeat (8) @(posedge clk);
		done <= 1'b1;
		@(posedge clk);
		#1;
		if (fail_count == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

// File: testbench/cpu_checker.sv
module cpu_checker (
	input  logic                clk,
	input  logic                rst,
	input  logic                exp_valid,
	input  logic                exp_write,
	input  logic [2:0]          exp_reg,
	input  logic [15:0]         exp_val,
	input  logic                exp_err,
	input  pipe_pkg::wb_event_t result,
	input  logic                err,
	input  logic                done,
	output int                  fail_count,
	output int                  pending
);

	timeunit 1ns;
	timeprecision 100ps;

	int          wr_idx_q[$];
	logic [2:0]  wr_reg_q[$];
	logic [15:0] wr_val_q[$];
	int          err_idx_q[$];
	int          test_idx = 0;
	int          pass_count = 0;

	initial fail_count = 0;

	always @(posedge clk) begin
		int idx;
		logic [2:0] reg_e;
		logic [15:0] val_e;
		if (!rst) begin
			if (result.valid) begin
				if (wr_idx_q.size() == 0) begin
					$display("Unexpected result strobe at %0t ns for r%0d", $time, result.dst);
					fail_count = fail_count + 1;
				end else begin
					idx = wr_idx_q.pop_front();
					reg_e = wr_reg_q.pop_front();
					val_e = wr_val_q.pop_front();
					if (result.dst !== reg_e || result.data !== val_e) begin
						$display("Mismatch at %0t ns: test %0d wrote r%0d = %h, expected r%0d = %h",
							$time, idx, result.dst, result.data, reg_e, val_e);
						fail_count = fail_count + 1;
					end else begin
						$display("Test %0d ok: r%0d = %h", idx, reg_e, val_e);
						pass_count = pass_count + 1;
					end
				end
			end
			if (err) begin
				if (err_idx_q.size() == 0) begin
					$display("Unexpected err pulse at %0t ns", $time);
					fail_count = fail_count + 1;
				end else begin
					idx = err_idx_q.pop_front();
					$display("Test %0d ok: err reported", idx);
					pass_count = pass_count + 1;
				end
			end
			if (exp_valid) begin
				if (exp_write) begin
					wr_idx_q.push_back(test_idx);
					wr_reg_q.push_back(exp_reg);
					wr_val_q.push_back(exp_val);
				end
				if (exp_err)
					err_idx_q.push_back(test_idx);
				if (!exp_write && !exp_err) begin
					$display("Test %0d ok: no result expected", test_idx);
					pass_count = pass_count + 1;
				end
				test_idx = test_idx + 1;
			end
			if (done)
				$display("Totals: %0d passed, %0d failed", pass_count, fail_count);
		end
		pending = wr_idx_q.size() + err_idx_q.size();
	end

endmodule

// File: testbench/cpu_properties.sv
module cpu_properties (
	input logic                clk,
	input logic                rst,
	input logic                instr_valid,
	input pipe_pkg::wb_event_t result,
	input logic                err
);

	timeunit 1ns;
	timeprecision 100ps;

	// Fixed three-cycle latency from strobe to result
	// Strobe sampled on edge N, result sampled high on edge N+4
	result_latency: assert property (@(posedge clk) disable iff (rst)
		result.valid |-> $past(instr_valid, 4))
		else $error("result strobe without an instruction three cycles earlier");

	reset_err_low: assert property (@(posedge clk) $past(rst) |-> !err)
		else $error("err high right after reset");

	known_outputs: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(result.valid) && !$isunknown(err))
		else $error("result.valid or err unknown");

endmodule

// File: hw/cpu_top.sv
module cpu_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                instr_valid,
	input  isa_pkg::instr_u     instr,
	output pipe_pkg::wb_event_t result,
	output logic                err
);

	pipe_pkg::dec_exe_t  dec;
	pipe_pkg::exe_mem_t  exe;
	pipe_pkg::wb_event_t wb;
	pipe_pkg::fwd_e      fwd_rs;
	pipe_pkg::fwd_e      fwd_rt;

	assign result = wb;

	decode_stage u_decode (
		.clk         (clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb          (wb),
		.dec         (dec)
	);

	execute_stage u_execute (
		.clk     (clk),
		.rst     (rst),
		.dec     (dec),
		.fwd_rs  (fwd_rs),
		.fwd_rt  (fwd_rt),
		.mem_fwd (exe.result),
		.wb_fwd  (wb),
		.exe     (exe)
	);

	mem_wb_stage u_mem_wb (
		.clk (clk),
		.rst (rst),
		.exe (exe),
		.wb  (wb)
	);

	hazard_unit u_hazard (
		.dec    (dec),
		.exe    (exe),
		.wb     (wb),
		.fwd_rs (fwd_rs),
		.fwd_rt (fwd_rt),
		.err    (err)
	);

endmodule

// File: hw/hazard_unit.sv
module hazard_unit (
	input  pipe_pkg::dec_exe_t  dec,
	input  pipe_pkg::exe_mem_t  exe,
	input  pipe_pkg::wb_event_t wb,
	output pipe_pkg::fwd_e      fwd_rs,
	output pipe_pkg::fwd_e      fwd_rt,
	output logic                err
);

	logic rs_used;
	logic rt_used;

	function automatic logic mem_hit(isa_pkg::reg_idx_t idx);
		return exe.valid && exe.reg_write && exe.dst == idx;
	endfunction

	// Memory stage first, a load there has no data yet
	function automatic pipe_pkg::fwd_e fwd_sel(isa_pkg::reg_idx_t idx);
		if (mem_hit(idx))
			return exe.mem_read ? pipe_pkg::FWD_NONE : pipe_pkg::FWD_MEM;
		if (wb.valid && wb.dst == idx)
			return pipe_pkg::FWD_WB;
		return pipe_pkg::FWD_NONE;
	endfunction

	assign rs_used = !(dec.opcode == isa_pkg::OP_NOP || dec.opcode == isa_pkg::OP_LBI);
	assign rt_used = dec.opcode == isa_pkg::OP_ALU_SHIFT || dec.opcode == isa_pkg::OP_ALU_ARITH ||
		dec.opcode == isa_pkg::OP_ST;

	assign fwd_rs = fwd_sel(dec.rs);
	assign fwd_rt = fwd_sel(dec.rt);

	// Load-use one cycle apart cannot be covered without a stall
	assign err = dec.illegal ||
		(dec.valid && exe.mem_read && rs_used && mem_hit(dec.rs)) ||
		(dec.valid && exe.mem_read && rt_used && mem_hit(dec.rt));

endmodule

// File: hw/mem_wb_stage.sv
`include "cpu_cfg.svh"

module mem_wb_stage (
	input  logic                clk,
	input  logic                rst,
	input  pipe_pkg::exe_mem_t  exe,
	output pipe_pkg::wb_event_t wb
);

	isa_pkg::word_t          dmem [2**`CPU_DMEM_AW];
	logic [`CPU_DMEM_AW-1:0] addr;

	// Word index from the low address bits
	assign addr = exe.result[`CPU_DMEM_AW-1:0];

	always_ff @(posedge clk) begin
		if (exe.valid && exe.mem_write)
			dmem[addr] <= exe.st_data;
	end

	// Load data is read on the same edge that loads write-back
	always_ff @(posedge clk) begin
		wb.dst <= exe.dst;
		if (exe.mem_read)
			wb.data <= dmem[addr];
		else
			wb.data <= exe.result;
		if (rst)
			wb.valid <= 1'b0;
		else
			wb.valid <= exe.valid & exe.reg_write;
	end

endmodule

// File: hw/execute_stage.sv
`include "cpu_cfg.svh"

module execute_stage (
	input  logic                clk,
	input  logic                rst,
	input  pipe_pkg::dec_exe_t  dec,
	input  pipe_pkg::fwd_e      fwd_rs,
	input  pipe_pkg::fwd_e      fwd_rt,
	input  isa_pkg::word_t      mem_fwd,
	input  pipe_pkg::wb_event_t wb_fwd,
	output pipe_pkg::exe_mem_t  exe
);

	isa_pkg::word_t           op_a;
	isa_pkg::word_t           rt_op;
	isa_pkg::word_t           op_b;
	isa_pkg::funct_e          alu_fn;
	logic [3:0]               amt;
	logic [2*`CPU_DATA_W-1:0] rol_full;
	logic [2*`CPU_DATA_W-1:0] ror_full;
	isa_pkg::word_t           add_res;
	isa_pkg::word_t           arith_res;
	isa_pkg::word_t           shift_res;
	isa_pkg::word_t           result;

	function automatic isa_pkg::word_t fwd_pick(pipe_pkg::fwd_e sel, isa_pkg::word_t rf_val);
		case (sel)
			pipe_pkg::FWD_MEM: return mem_fwd;
			pipe_pkg::FWD_WB:  return wb_fwd.data;
			default:           return rf_val;
		endcase
	endfunction

	assign op_a  = fwd_pick(fwd_rs, dec.rs_val);
	assign rt_op = fwd_pick(fwd_rt, dec.rt_val);

	// Second operand
	always_comb begin
		case (dec.opcode)
			isa_pkg::OP_ADDI, isa_pkg::OP_SUBI, isa_pkg::OP_LD, isa_pkg::OP_ST:
				op_b = {{(`CPU_DATA_W-5){dec.imm5[4]}}, dec.imm5};
			isa_pkg::OP_XORI, isa_pkg::OP_ANDNI:
				op_b = {{(`CPU_DATA_W-5){1'b0}}, dec.imm5};
			isa_pkg::OP_ROLI, isa_pkg::OP_SLLI, isa_pkg::OP_RORI, isa_pkg::OP_SRLI:
				op_b = {{(`CPU_DATA_W-4){1'b0}}, dec.imm5[3:0]};
			default:
				op_b = rt_op;
		endcase
	end

	// Immediate opcodes carry the function in their low two bits
	assign alu_fn = (dec.opcode == isa_pkg::OP_ALU_SHIFT || dec.opcode == isa_pkg::OP_ALU_ARITH) ?
		dec.funct : isa_pkg::funct_e'(dec.opcode[1:0]);

	assign amt      = op_b[3:0];
	assign rol_full = {op_a, op_a} << amt;
	assign ror_full = {op_a, op_a} >> amt;
	assign add_res  = op_a + op_b;

	always_comb begin
		case (alu_fn)
			isa_pkg::FN_ADD_ROL: begin
				arith_res = add_res;
				shift_res = rol_full[2*`CPU_DATA_W-1:`CPU_DATA_W];
			end
			// Subtract is reversed, rt or imm minus rs
			isa_pkg::FN_SUB_SLL: begin
				arith_res = op_b - op_a;
				shift_res = op_a << amt;
			end
			isa_pkg::FN_XOR_ROR: begin
				arith_res = op_a ^ op_b;
				shift_res = ror_full[`CPU_DATA_W-1:0];
			end
			default: begin
				arith_res = op_a & ~op_b;
				shift_res = op_a >> amt;
			end
		endcase
	end

	// Output select
	always_comb begin
		case (dec.opcode)
			isa_pkg::OP_LBI:
				result = {{(`CPU_DATA_W-8){dec.imm8[7]}}, dec.imm8};
			isa_pkg::OP_SLBI:
				result = {op_a[`CPU_DATA_W-9:0], dec.imm8};
			isa_pkg::OP_LD, isa_pkg::OP_ST:
				result = add_res;
			isa_pkg::OP_ROLI, isa_pkg::OP_SLLI, isa_pkg::OP_RORI, isa_pkg::OP_SRLI,
			isa_pkg::OP_ALU_SHIFT:
				result = shift_res;
			default:
				result = arith_res;
		endcase
	end

	always_ff @(posedge clk) begin
		exe.dst     <= dec.dst;
		exe.result  <= result;
		exe.st_data <= rt_op;
		if (rst) begin
			exe.valid     <= 1'b0;
			exe.reg_write <= 1'b0;
			exe.mem_read  <= 1'b0;
			exe.mem_write <= 1'b0;
		end else begin
			exe.valid     <= dec.valid;
			exe.reg_write <= dec.reg_write;
			exe.mem_read  <= dec.mem_read;
			exe.mem_write <= dec.mem_write;
		end
	end

endmodule

// File: hw/decode_stage.sv
module decode_stage (
	input  logic                clk,
	input  logic                rst,
	input  logic                instr_valid,
	input  isa_pkg::instr_u     instr,
	input  pipe_pkg::wb_event_t wb,
	output pipe_pkg::dec_exe_t  dec
);

	logic              valid_q;
	isa_pkg::instr_u   instr_q;
	logic              reg_write;
	logic              mem_read;
	logic              mem_write;
	logic              illegal;
	isa_pkg::reg_idx_t dst;
	isa_pkg::word_t    rs_val;
	isa_pkg::word_t    rt_val;

	// Instruction capture
	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= instr_valid;
		if (instr_valid)
			instr_q <= instr;
	end

	always_comb begin
		reg_write = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		illegal   = 1'b0;
		dst       = instr_q.i1_fmt.rd;
		case (instr_q.r_fmt.opcode)
			isa_pkg::OP_NOP: ;
			isa_pkg::OP_ADDI, isa_pkg::OP_SUBI, isa_pkg::OP_XORI, isa_pkg::OP_ANDNI,
			isa_pkg::OP_ROLI, isa_pkg::OP_SLLI, isa_pkg::OP_RORI, isa_pkg::OP_SRLI:
				reg_write = 1'b1;
			isa_pkg::OP_LD: begin
				reg_write = 1'b1;
				mem_read  = 1'b1;
			end
			isa_pkg::OP_ST:
				mem_write = 1'b1;
			// Byte loads target their own rs field
			isa_pkg::OP_LBI, isa_pkg::OP_SLBI: begin
				reg_write = 1'b1;
				dst       = instr_q.i2_fmt.rs;
			end
			isa_pkg::OP_ALU_SHIFT, isa_pkg::OP_ALU_ARITH: begin
				reg_write = 1'b1;
				dst       = instr_q.r_fmt.rd;
			end
			default:
				illegal = 1'b1;
		endcase
	end

	reg_file rf (
		.clk    (clk),
		.rst    (rst),
		.rs_idx (instr_q.r_fmt.rs),
		.rt_idx (instr_q.r_fmt.rt),
		.wr     (wb),
		.rs_val (rs_val),
		.rt_val (rt_val)
	);

	always_ff @(posedge clk) begin
		dec.opcode <= instr_q.r_fmt.opcode;
		dec.funct  <= instr_q.r_fmt.funct;
		dec.rs     <= instr_q.r_fmt.rs;
		dec.rt     <= instr_q.r_fmt.rt;
		dec.rs_val <= rs_val;
		dec.rt_val <= rt_val;
		dec.dst    <= dst;
		dec.imm5   <= instr_q.i1_fmt.imm5;
		dec.imm8   <= instr_q.i2_fmt.imm8;
		if (rst) begin
			dec.valid     <= 1'b0;
			dec.illegal   <= 1'b0;
			dec.reg_write <= 1'b0;
			dec.mem_read  <= 1'b0;
			dec.mem_write <= 1'b0;
		end else begin
			dec.valid     <= valid_q;
			dec.illegal   <= valid_q & illegal;
			dec.reg_write <= valid_q & reg_write;
			dec.mem_read  <= valid_q & mem_read;
			dec.mem_write <= valid_q & mem_write;
		end
	end

endmodule

// File: hw/reg_file.sv
`include "cpu_cfg.svh"

module reg_file (
	input  logic                clk,
	input  logic                rst,
	input  isa_pkg::reg_idx_t   rs_idx,
	input  isa_pkg::reg_idx_t   rt_idx,
	input  pipe_pkg::wb_event_t wr,
	output isa_pkg::word_t      rs_val,
	output isa_pkg::word_t      rt_val
);

	isa_pkg::word_t regs [`CPU_REG_CNT];

	// Write in flight wins over the stored value
	function automatic isa_pkg::word_t read_port(isa_pkg::reg_idx_t idx);
		if (wr.valid && wr.dst == idx)
			return wr.data;
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `CPU_REG_CNT; i++)
				regs[i] <= '0;
		end else if (wr.valid) begin
			regs[wr.dst] <= wr.data;
		end
	end

	assign rs_val = read_port(rs_idx);
	assign rt_val = read_port(rt_idx);

endmodule

// File: hw/pipe_pkg.sv
package pipe_pkg;

	// Operand source in execute
	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_MEM  = 2'b01,
		FWD_WB   = 2'b10
	} fwd_e;

	// Decode to execute
	typedef struct packed {
		logic             valid;
		logic             illegal;
		isa_pkg::opcode_e opcode;
		isa_pkg::funct_e  funct;
		isa_pkg::reg_idx_t rs;
		isa_pkg::reg_idx_t rt;
		isa_pkg::word_t   rs_val;
		isa_pkg::word_t   rt_val;
		isa_pkg::reg_idx_t dst;
		logic             reg_write;
		logic             mem_read;
		logic             mem_write;
		logic [4:0]       imm5;
		logic [7:0]       imm8;
	} dec_exe_t;

	// Execute to memory, result holds the address for LD and ST
	typedef struct packed {
		logic              valid;
		isa_pkg::reg_idx_t dst;
		logic              reg_write;
		logic              mem_read;
		logic              mem_write;
		isa_pkg::word_t    result;
		isa_pkg::word_t    st_data;
	} exe_mem_t;

	// One register write, also the result strobe
	typedef struct packed {
		logic              valid;
		isa_pkg::reg_idx_t dst;
		isa_pkg::word_t    data;
	} wb_event_t;

endpackage

// File: hw/isa_pkg.sv
`include "cpu_cfg.svh"

package isa_pkg;

	typedef logic [`CPU_DATA_W-1:0] word_t;
	typedef logic [$clog2(`CPU_REG_CNT)-1:0] reg_idx_t;

	// Low two bits of the immediate ALU and shift opcodes follow funct_e
	typedef enum logic [4:0] {
		OP_NOP       = 5'b00001,
		OP_ADDI      = 5'b01000,
		OP_SUBI      = 5'b01001,
		OP_XORI      = 5'b01010,
		OP_ANDNI     = 5'b01011,
		OP_ST        = 5'b10000,
		OP_LD        = 5'b10001,
		OP_SLBI      = 5'b10010,
		OP_ROLI      = 5'b10100,
		OP_SLLI      = 5'b10101,
		OP_RORI      = 5'b10110,
		OP_SRLI      = 5'b10111,
		OP_LBI       = 5'b11000,
		OP_ALU_SHIFT = 5'b11010,
		OP_ALU_ARITH = 5'b11011
	} opcode_e;

	// Arithmetic name first, shift name second
	typedef enum logic [1:0] {
		FN_ADD_ROL  = 2'b00,
		FN_SUB_SLL  = 2'b01,
		FN_XOR_ROR  = 2'b10,
		FN_ANDN_SRL = 2'b11
	} funct_e;

	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		funct_e   funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   rs;
		reg_idx_t   rd;
		logic [4:0] imm5;
	} i1_fmt_t;

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   rs;
		logic [7:0] imm8;
	} i2_fmt_t;

	typedef union packed {
		r_fmt_t  r_fmt;
		i1_fmt_t i1_fmt;
		i2_fmt_t i2_fmt;
	} instr_u;

endpackage

// File: hw/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Core sizing shared by the packages and the RTL

// Data path and instruction word width
`define CPU_DATA_W 16

// General registers
`define CPU_REG_CNT 8

// Word address bits of the data memory
`define CPU_DMEM_AW 8

`endif
